//--- common/uart_cfg_pkg.sv
`default_nettype none

package uart_cfg_pkg;

    // ============================================================
    // Clock domain and line rate
    // ============================================================

    localparam int CLK_FREQ_HZ  = 20_000_000;
    localparam int DEFAULT_BAUD = 230_400;

    // Rounded to the nearest whole cycle, 87 at these rates.
    localparam int DEFAULT_CLKS_PER_BIT = (CLK_FREQ_HZ + DEFAULT_BAUD / 2) / DEFAULT_BAUD;

    // ============================================================
    // Buffering and frame format
    // ============================================================

    localparam int DEFAULT_RX_DEPTH = 8;
    localparam int DEFAULT_TX_DEPTH = 4;

    // Data bits per 8N1 frame.
    localparam int DATA_BITS = 8;

endpackage

`default_nettype wire

//--- common/uart_frame_pkg.sv
`default_nettype none

package uart_frame_pkg;

    // One data byte as carried on the serial line.
    typedef logic [7:0] uart_byte_t;

    // Received word handed to the host.
    typedef struct packed {
        logic       frame_err;
        uart_byte_t data;
    } rx_word_t;

endpackage

`default_nettype wire

//--- rtl/credit_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module credit_fifo #(
    parameter type PAYLOAD_T        = logic [7:0],
    parameter int  DEPTH            = 4,
    parameter int  INIT_OUT_CREDITS = 0
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     in_valid,
    input  PAYLOAD_T in_data,
    output logic     in_credit,
    output logic     out_valid,
    output PAYLOAD_T out_data,
    input  logic     out_credit
);

    localparam int PTR_W      = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W      = $clog2(DEPTH + 1);
    // Receiver may bank several credits ahead of the data.
    localparam int CREDIT_MAX = 4 * DEPTH;
    localparam int CRD_W      = $clog2(CREDIT_MAX + 1);

    PAYLOAD_T         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CRD_W-1:0] out_credits;
    logic             pop;

    // An incoming word or credit counts in the same cycle.
    assign pop = ((count != '0) || in_valid) && ((out_credits != '0) || out_credit);

    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_data;
        end
        if (pop) begin
            out_data <= (count == '0) ? in_data : mem[rd_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            out_credits <= CRD_W'(INIT_OUT_CREDITS);
            out_valid   <= 1'b0;
            in_credit   <= 1'b0;
        end else begin
            out_valid <= pop;
            in_credit <= pop;
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({out_credit, pop})
                2'b10:   out_credits <= out_credits + 1'b1;
                2'b01:   out_credits <= out_credits - 1'b1;
                default: out_credits <= out_credits;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!reset_n) in_valid |-> count != CNT_W'(DEPTH))
        else $error("credit_fifo written while full");

    assert property (@(posedge clk) disable iff (!reset_n) out_credits <= CRD_W'(CREDIT_MAX))
        else $error("credit_fifo output credits above limit");

endmodule

`default_nettype wire

//--- rtl/uart_core.sv
`timescale 1ns/10ps
`default_nettype none

module uart_core #(
    parameter int CLKS_PER_BIT = uart_cfg_pkg::DEFAULT_CLKS_PER_BIT,
    parameter int RX_DEPTH     = uart_cfg_pkg::DEFAULT_RX_DEPTH,
    parameter int TX_DEPTH     = uart_cfg_pkg::DEFAULT_TX_DEPTH
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       rx,
    output logic                       tx,
    output logic                       rx_valid,
    output uart_frame_pkg::rx_word_t   rx_data,
    input  logic                       rx_credit,
    output logic                       overrun,
    input  logic                       tx_valid,
    input  uart_frame_pkg::uart_byte_t tx_data,
    output logic                       tx_credit
);

    import uart_frame_pkg::*;

    // ============================================================
    // Receive path
    // ============================================================

    logic     rx_push;
    rx_word_t rx_word;
    logic     rx_fifo_credit;

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .RX_DEPTH     (RX_DEPTH)
    ) u_rx (
        .clk     (clk),
        .reset_n (reset_n),
        .rx      (rx),
        .push    (rx_push),
        .word    (rx_word),
        .credit  (rx_fifo_credit),
        .overrun (overrun)
    );

    // Host grants every output credit.
    credit_fifo #(
        .PAYLOAD_T        (rx_word_t),
        .DEPTH            (RX_DEPTH),
        .INIT_OUT_CREDITS (0)
    ) u_rx_fifo (
        .clk        (clk),
        .reset_n    (reset_n),
        .in_valid   (rx_push),
        .in_data    (rx_word),
        .in_credit  (rx_fifo_credit),
        .out_valid  (rx_valid),
        .out_data   (rx_data),
        .out_credit (rx_credit)
    );

    // ============================================================
    // Transmit path
    // ============================================================

    logic       txf_valid;
    uart_byte_t txf_data;
    logic       tx_done;

    // One credit, the transmitter takes a byte at a time.
    credit_fifo #(
        .PAYLOAD_T        (uart_byte_t),
        .DEPTH            (TX_DEPTH),
        .INIT_OUT_CREDITS (1)
    ) u_tx_fifo (
        .clk        (clk),
        .reset_n    (reset_n),
        .in_valid   (tx_valid),
        .in_data    (tx_data),
        .in_credit  (tx_credit),
        .out_valid  (txf_valid),
        .out_data   (txf_data),
        .out_credit (tx_done)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_tx (
        .clk     (clk),
        .reset_n (reset_n),
        .valid   (txf_valid),
        .data    (txf_data),
        .credit  (tx_done),
        .tx      (tx)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_uart_core -f tb.f \
    || { echo "run_sim: build failed"; exit 1; }

sim_out="$(./obj_dir/Vtb_uart_core 2>&1)"
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -qx "TEST RESULT: PASS" \
    && { echo "run_sim: simulation passed"; exit 0; } \
    || { echo "run_sim: simulation failed"; exit 1; }

//--- tb.f
common/uart_cfg_pkg.sv
common/uart_frame_pkg.sv
rtl/credit_fifo.sv
uart_rx/uart_rx.sv
uart_tx/uart_tx.sv
rtl/uart_core.sv
verif/tb_uart_core.sv

//--- uart_rx/uart_rx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_rx #(
    parameter int CLKS_PER_BIT = uart_cfg_pkg::DEFAULT_CLKS_PER_BIT,
    parameter int RX_DEPTH     = uart_cfg_pkg::DEFAULT_RX_DEPTH
) (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     rx,
    output logic                     push,
    output uart_frame_pkg::rx_word_t word,
    input  logic                     credit,
    output logic                     overrun
);

    import uart_cfg_pkg::*;
    import uart_frame_pkg::*;

    localparam int CYC_W  = $clog2(CLKS_PER_BIT);
    localparam int BIT_W  = $clog2(DATA_BITS);
    localparam int CRED_W = $clog2(RX_DEPTH + 1);
    localparam int HALF   = CLKS_PER_BIT / 2;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START_HALF,
        RX_DATA_WAIT,
        RX_SAMPLE,
        RX_STOP
    } rx_state_t;

    rx_state_t        state;
    logic [CYC_W-1:0] cyc_cnt;
    logic [BIT_W-1:0] bit_cnt;
    uart_byte_t       shift_q;
    logic [CRED_W-1:0] credit_cnt;
    logic             stop_mid;

    // Middle of the stop bit, where the frame is judged.
    assign stop_mid = (state == RX_STOP) && (cyc_cnt == CYC_W'(CLKS_PER_BIT - 1));

    // ============================================================
    // Frame FSM
    // ============================================================

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state   <= RX_IDLE;
            cyc_cnt <= '0;
            bit_cnt <= '0;
            push    <= 1'b0;
            overrun <= 1'b0;
        end else begin
            push <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cyc_cnt <= '0;
                    bit_cnt <= '0;
                    if (!rx) begin
                        state <= RX_START_HALF;
                    end
                end
                RX_START_HALF: begin
                    // A glitch shorter than half a bit is not a start.
                    if (cyc_cnt == CYC_W'(HALF - 1)) begin
                        cyc_cnt <= '0;
                        state   <= rx ? RX_IDLE : RX_DATA_WAIT;
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                RX_DATA_WAIT: begin
                    if (cyc_cnt == CYC_W'(CLKS_PER_BIT - 2)) begin
                        cyc_cnt <= '0;
                        state   <= RX_SAMPLE;
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                RX_SAMPLE: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    state   <= (bit_cnt == BIT_W'(DATA_BITS - 1)) ? RX_STOP : RX_DATA_WAIT;
                end
                RX_STOP: begin
                    if (stop_mid) begin
                        cyc_cnt <= '0;
                        state   <= RX_IDLE;
                        if (credit_cnt != '0) begin
                            push <= 1'b1;
                        end else begin
                            overrun <= 1'b1;
                        end
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first.
    always_ff @(posedge clk) begin
        if (state == RX_SAMPLE) begin
            shift_q <= {rx, shift_q[DATA_BITS-1:1]};
        end
        if (stop_mid) begin
            word.frame_err <= ~rx;
            word.data      <= shift_q;
        end
    end

    // Free slots in the receive FIFO.
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            credit_cnt <= CRED_W'(RX_DEPTH);
        end else begin
            case ({credit, push})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!reset_n)
                     credit |-> credit_cnt != CRED_W'(RX_DEPTH))
        else $error("uart_rx got a FIFO credit while holding every credit");

endmodule

`default_nettype wire

//--- uart_tx/uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = uart_cfg_pkg::DEFAULT_CLKS_PER_BIT
) (
    input  logic                       clk,
    input  logic                       reset_n,
    input  logic                       valid,
    input  uart_frame_pkg::uart_byte_t data,
    output logic                       credit,
    output logic                       tx
);

    import uart_cfg_pkg::*;
    import uart_frame_pkg::*;

    localparam int CYC_W = $clog2(CLKS_PER_BIT);
    localparam int BIT_W = $clog2(DATA_BITS);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    tx_state_t        state;
    logic [CYC_W-1:0] cyc_cnt;
    logic [BIT_W-1:0] bit_cnt;
    uart_byte_t       shift_q;
    logic             bit_end;
    logic             shift_en;

    assign bit_end  = (cyc_cnt == CYC_W'(CLKS_PER_BIT - 1));
    assign shift_en = bit_end && ((state == TX_START) || (state == TX_DATA));

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state   <= TX_IDLE;
            cyc_cnt <= '0;
            bit_cnt <= '0;
            tx      <= 1'b1;
            credit  <= 1'b0;
        end else begin
            credit <= 1'b0;
            if (state != TX_IDLE) begin
                cyc_cnt <= bit_end ? '0 : cyc_cnt + 1'b1;
            end
            case (state)
                TX_IDLE: begin
                    cyc_cnt <= '0;
                    bit_cnt <= '0;
                    if (valid) begin
                        tx    <= 1'b0;
                        state <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        tx    <= shift_q[0];
                        state <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_W'(DATA_BITS - 1)) begin
                            tx    <= 1'b1;
                            state <= TX_STOP;
                        end else begin
                            tx <= shift_q[0];
                        end
                    end
                end
                TX_STOP: begin
                    // Line stays high, the FIFO may send the next byte.
                    if (bit_end) begin
                        credit <= 1'b1;
                        state  <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == TX_IDLE) && valid) begin
            shift_q <= data;
        end else if (shift_en) begin
            shift_q <= {1'b0, shift_q[DATA_BITS-1:1]};
        end
    end

    assert property (@(posedge clk) disable iff (!reset_n) valid |-> state == TX_IDLE)
        else $error("uart_tx got a byte while a frame was in progress");

endmodule

`default_nettype wire

//--- verif/tb_uart_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_uart_core;

    import uart_frame_pkg::*;

    localparam int CLKS_PER_BIT = 8;
    localparam int RX_DEPTH     = 4;
    localparam int TX_DEPTH     = 4;
    localparam int MAX_STEPS    = 64;

    localparam int OP_RX_FRAME  = 0;
    localparam int OP_GRANT     = 1;
    localparam int OP_SEND      = 2;
    localparam int OP_OVERRUN   = 3;

    logic       clk;
    logic       reset_n;
    logic       rx;
    logic       tx;
    logic       rx_valid;
    rx_word_t   rx_data;
    logic       rx_credit;
    logic       overrun;
    logic       tx_valid;
    uart_byte_t tx_data;
    logic       tx_credit;

    int         step_op   [MAX_STEPS];
    logic [7:0] step_byte [MAX_STEPS];
    logic       step_stop [MAX_STEPS];
    logic       step_flag [MAX_STEPS];
    int         step_count;

    rx_word_t    exp_rx [$];
    uart_byte_t  exp_tx [$];
    int          rx_host_credits;
    int          tx_credit_pulses;
    int          tx_sent;
    int          cycle_cnt;
    int          cycle_limit;
    int          error_count;
    logic [31:0] lcg_state;

    uart_core #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .RX_DEPTH     (RX_DEPTH),
        .TX_DEPTH     (TX_DEPTH)
    ) u_uart_core (
        .clk       (clk),
        .reset_n   (reset_n),
        .rx        (rx),
        .tx        (tx),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .rx_credit (rx_credit),
        .overrun   (overrun),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .tx_credit (tx_credit)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic stop_on_error(input string why);
        error_count++;
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_on_error($sformatf("[FAIL] t=%0t %s actual=0x%0h expected=0x%0h",
                                    $time, name, actual, expected));
        end
    endtask

    // Start bit, LSB first data, stop bit, then at least one idle bit.
    task automatic drive_serial_frame(input logic [7:0] data_byte, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, data_byte, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= bits[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
        @(posedge clk);
        rx <= 1'b1;
        repeat (CLKS_PER_BIT) @(posedge clk);
    endtask

    task automatic grant_rx_credits(input int count);
        repeat (count) begin
            @(posedge clk);
            rx_credit <= 1'b1;
        end
        @(posedge clk);
        rx_credit <= 1'b0;
        // Granted words drain before the next step.
        repeat (4) @(posedge clk);
    endtask

    task automatic send_host_byte(input logic [7:0] data_byte);
        @(negedge clk);
        while (TX_DEPTH + tx_credit_pulses - tx_sent == 0) @(negedge clk);
        @(posedge clk);
        tx_valid <= 1'b1;
        tx_data  <= data_byte;
        tx_sent++;
        exp_tx.push_back(data_byte);
        @(posedge clk);
        tx_valid <= 1'b0;
    endtask

    // ============================================================
    // Monitors
    // ============================================================

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            stop_on_error($sformatf("Run hung: still busy after %0d clock cycles", cycle_cnt));
        end
    end

    always @(posedge clk) begin : rx_monitor
        rx_word_t expected;
        if (reset_n && rx_valid) begin
            if (rx_host_credits == 0) begin
                stop_on_error("rx_valid rose while the host held no receive credit");
            end else if (exp_rx.size() == 0) begin
                stop_on_error("rx_valid delivered a word that no frame accounts for");
            end else begin
                expected = exp_rx.pop_front();
                rx_host_credits--;
                check_value("rx_data.data", 32'(rx_data.data), 32'(expected.data));
                check_value("rx_data.frame_err", 32'(rx_data.frame_err),
                            32'(expected.frame_err));
            end
        end
        if (reset_n && rx_credit) begin
            rx_host_credits++;
        end
    end

    always @(posedge clk) begin
        if (reset_n && tx_credit) begin
            tx_credit_pulses++;
            if (tx_credit_pulses > tx_sent) begin
                stop_on_error("tx_credit returned more credits than bytes were sent");
            end
        end
    end

    // Every sample inside a bit must match, so each bit spans exactly CLKS_PER_BIT cycles.
    initial begin : tx_monitor
        logic [9:0] bits;
        logic       level;
        forever begin
            @(posedge clk);
            if (reset_n && tx === 1'b0) begin
                for (int i = 0; i < 10; i++) begin
                    for (int c = 0; c < CLKS_PER_BIT; c++) begin
                        if (i != 0 || c != 0) begin
                            @(posedge clk);
                        end
                        if (c == 0) begin
                            level = tx;
                        end else begin
                            check_value("tx", 32'(tx), 32'(level));
                        end
                        if (c == CLKS_PER_BIT / 2) begin
                            bits[i] = tx;
                        end
                    end
                end
                check_value("tx stop bit", 32'(bits[9]), 32'd1);
                if (exp_tx.size() == 0) begin
                    stop_on_error("A frame appeared on tx with no byte sent by the host");
                end else begin
                    check_value("tx frame data", 32'(bits[8:1]), 32'(exp_tx.pop_front()));
                end
            end
        end
    end

    // ============================================================
    // Vector driven sequence
    // ============================================================

    initial begin : main
        int       fd;
        int       code;
        int       op_v;
        int       byte_v;
        int       stop_v;
        int       flag_v;
        int       gap;
        string    line;
        rx_word_t word_v;

        rx        = 1'b1;
        reset_n   = 1'b0;
        rx_credit = 1'b0;
        tx_valid  = 1'b0;
        tx_data   = '0;
        lcg_state        = 32'h65dd_adac;
        rx_host_credits  = 0;
        tx_credit_pulses = 0;
        tx_sent          = 0;
        cycle_cnt        = 0;
        cycle_limit      = 0;
        error_count      = 0;
        step_count       = 0;

        fd = $fopen("verif/uart_vectors.txt", "r");
        if (fd == 0) begin
            stop_on_error("Could not open verif/uart_vectors.txt");
        end
        while ($fgets(line, fd) != 0) begin
            code = $sscanf(line, "%h %h %h %h", op_v, byte_v, stop_v, flag_v);
            if (code == 4) begin
                if (step_count >= MAX_STEPS) begin
                    stop_on_error("The vector file holds more steps than the testbench can store");
                end
                step_op[step_count]   = op_v;
                step_byte[step_count] = byte_v[7:0];
                step_stop[step_count] = stop_v[0];
                step_flag[step_count] = flag_v[0];
                step_count++;
            end
        end
        $fclose(fd);
        cycle_limit = 2 * (step_count * 12 * CLKS_PER_BIT) + 500;

        repeat (5) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_value("tx", 32'(tx), 32'd1);
        check_value("rx_valid", 32'(rx_valid), 32'd0);
        check_value("tx_credit", 32'(tx_credit), 32'd0);
        check_value("overrun", 32'(overrun), 32'd0);

        for (int s = 0; s < step_count; s++) begin
            case (step_op[s])
                OP_RX_FRAME: begin
                    // A frame is kept only while the receive FIFO has a free slot.
                    @(negedge clk);
                    if (exp_rx.size() < RX_DEPTH) begin
                        word_v.frame_err = step_flag[s];
                        word_v.data      = step_byte[s];
                        exp_rx.push_back(word_v);
                    end
                    gap = int'((lcg_next() >> 24) & 32'hf);
                    repeat (gap) @(posedge clk);
                    drive_serial_frame(step_byte[s], step_stop[s]);
                end
                OP_GRANT: grant_rx_credits(int'(step_byte[s]));
                OP_SEND:  send_host_byte(step_byte[s]);
                OP_OVERRUN: begin
                    @(negedge clk);
                    check_value("overrun", 32'(overrun), 32'(step_flag[s]));
                end
                default: stop_on_error($sformatf("Unknown operation code %0d in step %0d",
                                                 step_op[s], s));
            endcase
        end

        @(negedge clk);
        while (exp_rx.size() != 0 || exp_tx.size() != 0) @(negedge clk);
        repeat (CLKS_PER_BIT) @(negedge clk);
        check_value("tx_credit pulse count", 32'(tx_credit_pulses), 32'(tx_sent));
        check_value("rx_valid", 32'(rx_valid), 32'd0);

        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "Checks failed.");
        end
    end

endmodule

`default_nettype wire

//--- verif/uart_vectors.txt
# Columns, all hex: op byte stop flag
# op 0 serial frame (flag = expected frame_err), 1 grant byte rx credits, 2 send byte, 3 overrun == flag
3 00 1 0
2 55 1 0
2 a3 1 0
1 02 1 0
0 a5 1 0
0 3c 1 0
0 5a 0 1
0 0f 1 0
1 01 1 0
1 01 1 0
2 00 1 0
2 ff 1 0
2 81 1 0
2 7e 1 0
2 e7 1 0
2 18 1 0
0 11 1 0
0 22 0 1
0 33 1 0
0 44 1 0
0 c6 1 0
3 00 1 1
1 04 1 0
3 00 1 1
